// ==== logic/link_pkg.sv ====
`default_nettype none

package link_pkg;

    // link message layout
    localparam int msg_width     = 64;
    localparam int payload_width = 32;

    // FPGA id of the receiving neighbor
    localparam int id_msb   = 63;
    localparam int id_lsb   = 56;
    localparam int id_width = id_msb - id_lsb + 1;

    // the tag byte holds the side bit on top of the channel index
    localparam int tag_msb   = 55;
    localparam int tag_lsb   = 48;
    localparam int tag_width = tag_msb - tag_lsb + 1;

    // 0 is north, 1 is south
    localparam int side_bit = 55;

    localparam int chan_msb   = 54;
    localparam int chan_lsb   = 48;
    localparam int chan_width = chan_msb - chan_lsb + 1;

    // tag byte of messages that belong to the control block
    localparam logic [tag_width-1:0] control_tag = '1;

endpackage

`default_nettype wire

// ==== logic/route_pkg.sv ====
`default_nettype none

package route_pkg;

    // where the head of the inbound FIFO goes
    typedef enum logic [1:0] {
        route_none    = 2'd0,
        route_north   = 2'd1,
        route_south   = 2'd2,
        route_control = 2'd3
    } route_t;

    // which source wins the outbound link in a cycle
    typedef enum logic [1:0] {
        src_none    = 2'd0,
        src_north   = 2'd1,
        src_south   = 2'd2,
        src_control = 2'd3
    } source_t;

endpackage

`default_nettype wire

// ==== logic/msg_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module msg_fifo #(
    parameter int width = 64,
    parameter int depth = 8
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [width-1:0] in_data,
    input  logic             in_valid,
    output logic             in_ready,
    output logic [width-1:0] out_data,
    output logic             out_valid,
    input  logic             out_ready
);

    localparam int ptr_width   = $clog2(depth);
    localparam int count_width = $clog2(depth + 1);

    logic [width-1:0]       mem [depth];
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [count_width-1:0] count;
    logic                   push;
    logic                   take;
    logic                   from_mem;
    logic                   bypass;
    logic                   to_mem;

    assign in_ready = (count != count_width'(depth));
    assign push     = in_valid && in_ready;

    // the output register can load when it is empty or drained this cycle
    assign take     = !out_valid || out_ready;
    assign from_mem = take && (count != '0);

    // with nothing stored, a new word skips the memory and goes straight out
    assign bypass   = take && (count == '0) && push;
    assign to_mem   = push && !bypass;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (to_mem) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (from_mem) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (to_mem && !from_mem) begin
                count <= count + 1'b1;
            end else if (from_mem && !to_mem) begin
                count <= count - 1'b1;
            end
            if (take) begin
                out_valid <= from_mem || bypass;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (to_mem) begin
            mem[wr_ptr] <= in_data;
        end
        if (from_mem) begin
            out_data <= mem[rd_ptr];
        end else if (bypass) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/border_combiner.sv ====
`timescale 1ns/1ps
`default_nettype none

module border_combiner import link_pkg::*; #(
    parameter int num_channels = 4
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [num_channels*payload_width-1:0] in_data,
    input  logic [num_channels-1:0]               in_valid,
    output logic [num_channels-1:0]               in_ready,
    output logic [msg_width-1:0]                  out_data,
    output logic                                  out_valid,
    input  logic                                  out_ready
);

    localparam int idx_width = (num_channels > 1) ? $clog2(num_channels) : 1;

    logic [idx_width-1:0] last;
    logic [idx_width-1:0] grant_idx;
    logic                 grant_valid;
    logic                 take;
    logic [msg_width-1:0] msg;

    // search starts one past the last winner and wraps around
    always_comb begin
        int cand;
        grant_valid = 1'b0;
        grant_idx   = '0;
        for (int i = 1; i <= num_channels; i++) begin
            cand = (int'(last) + i) % num_channels;
            if (!grant_valid && in_valid[cand]) begin
                grant_valid = 1'b1;
                grant_idx   = idx_width'(cand);
            end
        end
    end

    assign take = !out_valid || out_ready;

    always_comb begin
        for (int i = 0; i < num_channels; i++) begin
            in_ready[i] = take && grant_valid && (grant_idx == idx_width'(i));
        end
    end

    // id and side bit stay zero here, the top level stamps them
    always_comb begin
        msg                          = '0;
        msg[chan_msb:chan_lsb]       = chan_width'(grant_idx);
        msg[payload_width-1:0]       = in_data[grant_idx*payload_width +: payload_width];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            last      <= idx_width'(num_channels - 1);
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= grant_valid;
            if (grant_valid) begin
                last <= grant_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && grant_valid) begin
            out_data <= msg;
        end
    end

endmodule

`default_nettype wire

// ==== logic/border_splitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module border_splitter import link_pkg::*; #(
    parameter int num_channels = 4
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic [msg_width-1:0]                  in_data,
    input  logic                                  in_valid,
    output logic                                  in_ready,
    output logic [num_channels*payload_width-1:0] out_data,
    output logic [num_channels-1:0]               out_valid,
    input  logic [num_channels-1:0]               out_ready
);

    logic [msg_width-1:0]  held_data;
    logic                  held_valid;
    logic [chan_width-1:0] held_chan;
    logic [chan_width-1:0] in_chan;
    logic                  drained;

    assign held_chan = held_data[chan_msb:chan_lsb];
    assign in_chan   = in_data[chan_msb:chan_lsb];

    // every slice carries the payload, only the addressed channel sees valid
    always_comb begin
        logic hit;
        drained = 1'b0;
        for (int i = 0; i < num_channels; i++) begin
            hit          = held_valid && (held_chan == chan_width'(i));
            out_valid[i] = hit;
            out_data[i*payload_width +: payload_width] = held_data[payload_width-1:0];
            if (hit && out_ready[i]) begin
                drained = 1'b1;
            end
        end
    end

    assign in_ready = !held_valid || drained;

    always_ff @(posedge clk) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (in_ready) begin
            // a channel index past the last channel is accepted and dropped
            held_valid <= in_valid && (in_chan < chan_width'(num_channels));
        end
    end

    always_ff @(posedge clk) begin
        if (in_ready && in_valid) begin
            held_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// ==== logic/message_handler.sv ====
`timescale 1ns/1ps
`default_nettype none

module message_handler import link_pkg::*, route_pkg::*; #(
    parameter int num_channels = 4,
    parameter int fifo_depth   = 8
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [id_width-1:0]                     fpga_id,

    input  logic [msg_width-1:0]                    in_data,
    input  logic                                    in_valid,
    output logic                                    in_ready,

    output logic [msg_width-1:0]                    out_data,
    output logic                                    out_valid,
    input  logic                                    out_ready,

    input  logic [2*num_channels*payload_width-1:0] border_input_data,
    input  logic [2*num_channels-1:0]               border_input_valid,
    output logic [2*num_channels-1:0]               border_input_ready,

    output logic [2*num_channels*payload_width-1:0] border_output_data,
    output logic [2*num_channels-1:0]               border_output_valid,
    input  logic [2*num_channels-1:0]               border_output_ready,

    input  logic [msg_width-1:0]                    control_to_handler_data,
    input  logic                                    control_to_handler_valid,
    output logic                                    control_to_handler_ready,

    output logic [msg_width-1:0]                    handler_to_control_data,
    output logic                                    handler_to_control_valid,
    input  logic                                    handler_to_control_ready,

    output logic                                    router_busy
);

    localparam int side_data_width = num_channels * payload_width;

    logic [id_width-1:0]  north_id;
    logic [id_width-1:0]  south_id;

    logic [msg_width-1:0] north_msg;
    logic                 north_valid;
    logic                 north_ready;
    logic [msg_width-1:0] south_msg;
    logic                 south_valid;
    logic                 south_ready;
    logic [msg_width-1:0] north_stamped;
    logic [msg_width-1:0] south_stamped;

    source_t              grant;
    logic [msg_width-1:0] arb_data;
    logic                 arb_valid;
    logic                 arb_ready;

    logic [msg_width-1:0] head_data;
    logic                 head_valid;
    logic                 head_ready;
    route_t               route;
    logic                 north_split_ready;
    logic                 south_split_ready;

    assign router_busy = |border_input_valid;

    // neighbors sit one id below (north) and one above (south)
    always_ff @(posedge clk) begin
        if (reset) begin
            north_id <= '0;
            south_id <= '0;
        end else begin
            north_id <= fpga_id - 1'b1;
            south_id <= fpga_id + 1'b1;
        end
    end

    border_combiner #(
        .num_channels(num_channels)
    ) north_combiner (
        .clk      (clk),
        .reset    (reset),
        .in_data  (border_input_data[side_data_width-1:0]),
        .in_valid (border_input_valid[num_channels-1:0]),
        .in_ready (border_input_ready[num_channels-1:0]),
        .out_data (north_msg),
        .out_valid(north_valid),
        .out_ready(north_ready)
    );

    border_combiner #(
        .num_channels(num_channels)
    ) south_combiner (
        .clk      (clk),
        .reset    (reset),
        .in_data  (border_input_data[2*side_data_width-1:side_data_width]),
        .in_valid (border_input_valid[2*num_channels-1:num_channels]),
        .in_ready (border_input_ready[2*num_channels-1:num_channels]),
        .out_data (south_msg),
        .out_valid(south_valid),
        .out_ready(south_ready)
    );

    always_comb begin
        north_stamped                = north_msg;
        north_stamped[id_msb:id_lsb] = north_id;
        north_stamped[side_bit]      = 1'b0;
        south_stamped                = south_msg;
        south_stamped[id_msb:id_lsb] = south_id;
        south_stamped[side_bit]      = 1'b1;
    end

    // fixed priority, and nothing is granted while out_fifo is full
    always_comb begin
        grant = src_none;
        if (arb_ready) begin
            if (north_valid) begin
                grant = src_north;
            end else if (south_valid) begin
                grant = src_south;
            end else if (control_to_handler_valid) begin
                grant = src_control;
            end
        end
    end

    always_comb begin
        arb_data                 = north_stamped;
        arb_valid                = 1'b0;
        north_ready              = 1'b0;
        south_ready              = 1'b0;
        control_to_handler_ready = 1'b0;
        case (grant)
            src_north: begin
                arb_valid   = 1'b1;
                north_ready = 1'b1;
            end
            src_south: begin
                arb_data    = south_stamped;
                arb_valid   = 1'b1;
                south_ready = 1'b1;
            end
            src_control: begin
                arb_data                 = control_to_handler_data;
                arb_valid                = 1'b1;
                control_to_handler_ready = 1'b1;
            end
            default: begin
            end
        endcase
    end

    msg_fifo #(
        .width(msg_width),
        .depth(fifo_depth)
    ) out_fifo (
        .clk      (clk),
        .reset    (reset),
        .in_data  (arb_data),
        .in_valid (arb_valid),
        .in_ready (arb_ready),
        .out_data (out_data),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    msg_fifo #(
        .width(msg_width),
        .depth(fifo_depth)
    ) in_fifo (
        .clk      (clk),
        .reset    (reset),
        .in_data  (in_data),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out_data (head_data),
        .out_valid(head_valid),
        .out_ready(head_ready)
    );

    always_comb begin
        route = route_none;
        if (head_valid) begin
            if (head_data[tag_msb:tag_lsb] == control_tag) begin
                route = route_control;
            end else if (head_data[side_bit]) begin
                route = route_south;
            end else begin
                route = route_north;
            end
        end
    end

    // the head leaves in_fifo only once its destination takes it
    always_comb begin
        case (route)
            route_control: head_ready = handler_to_control_ready;
            route_north:   head_ready = north_split_ready;
            route_south:   head_ready = south_split_ready;
            default:       head_ready = 1'b0;
        endcase
    end

    assign handler_to_control_data  = head_data;
    assign handler_to_control_valid = (route == route_control);

    border_splitter #(
        .num_channels(num_channels)
    ) north_splitter (
        .clk      (clk),
        .reset    (reset),
        .in_data  (head_data),
        .in_valid (route == route_north),
        .in_ready (north_split_ready),
        .out_data (border_output_data[side_data_width-1:0]),
        .out_valid(border_output_valid[num_channels-1:0]),
        .out_ready(border_output_ready[num_channels-1:0])
    );

    border_splitter #(
        .num_channels(num_channels)
    ) south_splitter (
        .clk      (clk),
        .reset    (reset),
        .in_data  (head_data),
        .in_valid (route == route_south),
        .in_ready (south_split_ready),
        .out_data (border_output_data[2*side_data_width-1:side_data_width]),
        .out_valid(border_output_valid[2*num_channels-1:num_channels]),
        .out_ready(border_output_ready[2*num_channels-1:num_channels])
    );

endmodule

`default_nettype wire

// ==== verif/tb_message_handler.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_message_handler;

    localparam int num_channels  = 4;
    localparam int chans         = 2 * num_channels;
    localparam int border_total  = 1200;
    localparam int control_total = 200;
    localparam int link_total    = 600;
    // 2000 messages with up to 10 stalled cycles each
    localparam int cycle_limit   = 20000;
    localparam logic [7:0] fpga_id_value = 8'h10;
    localparam logic [7:0] north_id_exp  = fpga_id_value - 8'd1;
    localparam logic [7:0] south_id_exp  = fpga_id_value + 8'd1;

    logic clk = 1'b0;
    logic reset;
    logic [7:0] fpga_id;
    logic [63:0] in_data;
    logic in_valid;
    logic in_ready;
    logic [63:0] out_data;
    logic out_valid;
    logic out_ready;
    logic [chans*32-1:0] border_input_data;
    logic [chans-1:0] border_input_valid;
    logic [chans-1:0] border_input_ready;
    logic [chans*32-1:0] border_output_data;
    logic [chans-1:0] border_output_valid;
    logic [chans-1:0] border_output_ready;
    logic [63:0] control_to_handler_data;
    logic control_to_handler_valid;
    logic control_to_handler_ready;
    logic [63:0] handler_to_control_data;
    logic handler_to_control_valid;
    logic handler_to_control_ready;
    logic router_busy;

    // expected messages per destination are queued when the input handshake completes
    logic [63:0] out_q [chans][$];
    logic [63:0] ctl_out_q [$];
    logic [31:0] bout_q [chans][$];
    logic [63:0] hctl_q [$];

    logic [31:0] rng = 32'h233d;
    logic [chans-1:0] b_taken;
    logic c_taken;
    logic l_taken;
    int border_raised;
    int control_raised;
    int link_raised;
    int value_errors;
    int extra_errors;
    int cycle;

    message_handler #(
        .num_channels(num_channels)
    ) dut (
        .clk                     (clk),
        .reset                   (reset),
        .fpga_id                 (fpga_id),
        .in_data                 (in_data),
        .in_valid                (in_valid),
        .in_ready                (in_ready),
        .out_data                (out_data),
        .out_valid               (out_valid),
        .out_ready               (out_ready),
        .border_input_data       (border_input_data),
        .border_input_valid      (border_input_valid),
        .border_input_ready      (border_input_ready),
        .border_output_data      (border_output_data),
        .border_output_valid     (border_output_valid),
        .border_output_ready     (border_output_ready),
        .control_to_handler_data (control_to_handler_data),
        .control_to_handler_valid(control_to_handler_valid),
        .control_to_handler_ready(control_to_handler_ready),
        .handler_to_control_data (handler_to_control_data),
        .handler_to_control_valid(handler_to_control_valid),
        .handler_to_control_ready(handler_to_control_ready),
        .router_busy             (router_busy)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // a ready is low about one cycle in three
    function automatic logic ready_draw();
        return (next_rand() % 3) != 0;
    endfunction

    task automatic report_value(input string what, input logic [63:0] got,
                                input logic [63:0] exp);
        value_errors++;
        $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
    endtask

    task automatic report_extra(input string what);
        extra_errors++;
        $display("at time %0t the DUT delivered a message nobody sent: %s", $time, what);
    endtask

    task automatic check_outputs();
        logic [63:0] exp;
        logic ok;
        int idx;
        assert (router_busy == |border_input_valid)
            else report_value("router_busy", 64'(router_busy), 64'(|border_input_valid));
        if (out_valid && out_ready) begin
            if (out_data[55:48] == 8'hff) begin
                ok = ctl_out_q.size() != 0;
                assert (ok) else report_extra("control word on out_data");
                if (ok) begin
                    exp = ctl_out_q.pop_front();
                    assert (out_data == exp) else report_value("out_data control", out_data, exp);
                end
            end else begin
                idx = (out_data[55] ? num_channels : 0) + int'(out_data[54:48]);
                ok = out_data[54:48] < 7'(num_channels) && out_q[idx].size() != 0;
                assert (ok) else report_extra("border word on out_data");
                if (ok) begin
                    exp = out_q[idx].pop_front();
                    assert (out_data == exp) else report_value("out_data border", out_data, exp);
                end
            end
        end
        if (handler_to_control_valid && handler_to_control_ready) begin
            ok = hctl_q.size() != 0;
            assert (ok) else report_extra("word on handler_to_control_data");
            if (ok) begin
                exp = hctl_q.pop_front();
                assert (handler_to_control_data == exp)
                    else report_value("handler_to_control_data", handler_to_control_data, exp);
            end
        end
        for (int i = 0; i < chans; i++) begin
            if (border_output_valid[i] && border_output_ready[i]) begin
                ok = bout_q[i].size() != 0;
                assert (ok) else report_extra($sformatf("border output %0d", i));
                if (ok) begin
                    exp = 64'(bout_q[i].pop_front());
                    assert (border_output_data[i*32 +: 32] == exp[31:0])
                        else report_value($sformatf("border_output_data[%0d]", i),
                                          64'(border_output_data[i*32 +: 32]), exp);
                end
            end
        end
    endtask

    task automatic record_inputs();
        logic south;
        for (int i = 0; i < chans; i++) begin
            b_taken[i] = border_input_valid[i] && border_input_ready[i];
            south = i >= num_channels;
            if (b_taken[i]) begin
                out_q[i].push_back({south ? south_id_exp : north_id_exp, south,
                                    7'(i % num_channels), 16'h0, border_input_data[i*32 +: 32]});
            end
        end
        c_taken = control_to_handler_valid && control_to_handler_ready;
        if (c_taken) begin
            ctl_out_q.push_back(control_to_handler_data);
        end
        l_taken = in_valid && in_ready;
        if (l_taken) begin
            if (in_data[55:48] == 8'hff) begin
                hctl_q.push_back(in_data);
            end else begin
                bout_q[(in_data[55] ? num_channels : 0) + int'(in_data[54:48])].push_back(
                    in_data[31:0]);
            end
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        for (int i = 0; i < chans; i++) begin
            if (!border_input_valid[i] || b_taken[i]) begin
                r = next_rand();
                border_input_valid[i] = r[0] && border_raised < border_total;
                if (border_input_valid[i]) begin
                    border_input_data[i*32 +: 32] = next_rand();
                    border_raised++;
                end
            end
        end
        if (!control_to_handler_valid || c_taken) begin
            r = next_rand();
            control_to_handler_valid = r[0] && control_raised < control_total;
            if (control_to_handler_valid) begin
                // control block words carry the all-ones tag
                control_to_handler_data = {r[15:8], 8'hff, 16'(next_rand()), next_rand()};
                control_raised++;
            end
        end
        if (!in_valid || l_taken) begin
            r = next_rand();
            in_valid = r[0] && link_raised < link_total;
            if (in_valid) begin
                if (r[3:2] == 2'd0) begin
                    in_data = {r[31:24], 8'hff, 16'(next_rand()), next_rand()};
                end else begin
                    in_data = {r[31:24], r[4], 5'd0, r[6:5], 16'(next_rand()), next_rand()};
                end
                link_raised++;
            end
        end
        out_ready = ready_draw();
        handler_to_control_ready = ready_draw();
        for (int i = 0; i < chans; i++) begin
            border_output_ready[i] = ready_draw();
        end
    endtask

    function automatic logic queues_empty();
        logic empty;
        empty = ctl_out_q.size() == 0 && hctl_q.size() == 0;
        for (int i = 0; i < chans; i++) begin
            empty = empty && out_q[i].size() == 0 && bout_q[i].size() == 0;
        end
        return empty;
    endfunction

    initial begin
        logic finished;
        logic pending;
        reset = 1'b1;
        fpga_id = fpga_id_value;
        in_data = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        border_input_data = '0;
        border_input_valid = '0;
        border_output_ready = '0;
        control_to_handler_data = '0;
        control_to_handler_valid = 1'b0;
        handler_to_control_ready = 1'b0;
        b_taken = '0;
        c_taken = 1'b0;
        l_taken = 1'b0;
        finished = 1'b0;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        assert (!out_valid && !handler_to_control_valid && border_output_valid == '0)
            else report_value("valid outputs after reset",
                              64'({out_valid, handler_to_control_valid, border_output_valid}), 0);
        while (!finished && cycle < cycle_limit) begin
            @(posedge clk);
            #1;
            drive_inputs();
            @(negedge clk);
            cycle++;
            check_outputs();
            record_inputs();
            pending = (border_input_valid & ~b_taken) != '0 ||
                      (control_to_handler_valid && !c_taken) || (in_valid && !l_taken);
            finished = border_raised == border_total && control_raised == control_total &&
                       link_raised == link_total && !pending && queues_empty();
        end
        if (!finished) begin
            $display("timeout: messages still in flight after %0d cycles", cycle);
        end
        $display("errors: %0d wrong value, %0d unexpected message, %0d cycles run",
                 value_errors, extra_errors, cycle);
        if (!finished || value_errors != 0 || extra_errors != 0) begin
            $display("Test failed");
        end else begin
            $display("Test passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
logic/link_pkg.sv
logic/route_pkg.sv
logic/msg_fifo.sv
logic/border_combiner.sv
logic/border_splitter.sv
logic/message_handler.sv
verif/tb_message_handler.sv

// ==== run.sh ====
#!/bin/sh
# build and run the message handler testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_message_handler \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vtb_message_handler > sim.log 2>&1
cat sim.log
grep -qx "Test passed" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
